//--- verilog/regfile_consts.svh
// ----------------------------------------
// sizes of the register file and datapath
// the RTL is written for these values only
// and is not meant to work at other sizes
// ----------------------------------------

`ifndef REGFILE_CONSTS_SVH
`define REGFILE_CONSTS_SVH

// one register, operand or result
`define DATA_WIDTH 8

// register number
`define ADDR_WIDTH 2

// registers per bank, must equal 2**ADDR_WIDTH
`define REG_COUNT 4

`endif

//--- verilog/regfile_pkg.sv
// ----------------------------------------
// shared types of the register/ALU unit
// alu_op_t codes are fixed, stimulus uses them
// code 7 is unused and yields zero
// ----------------------------------------

`include "regfile_consts.svh"

package regfile_pkg;

    typedef logic [`DATA_WIDTH-1:0] data_t;     // register value or operand
    typedef logic [`ADDR_WIDTH-1:0] reg_addr_t; // register number

    // ALU operations
    typedef enum logic [2:0] {
        op_ldi = 3'd0,  // immediate
        op_mov = 3'd1,  // left operand
        op_add = 3'd2,
        op_sub = 3'd3,
        op_and = 3'd4,
        op_or  = 3'd5,
        op_xor = 3'd6
    } alu_op_t;

    // command controller
    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_exec = 2'd1,
        st_done = 2'd2
    } ctrl_state_t;

endpackage

//--- verilog/reg_bank.sv
// ----------------------------------------
// 4x8 register bank, one write, one read
// write is synchronous on clk
// read is combinational
// arst_n clears every register to zero
// ----------------------------------------

`timescale 1ns/1ps

`include "regfile_consts.svh"

module reg_bank (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   wr_en,
    input  regfile_pkg::reg_addr_t wr_addr,
    input  regfile_pkg::data_t     wr_data,
    input  regfile_pkg::reg_addr_t rd_addr,
    output regfile_pkg::data_t     rd_data
);

    regfile_pkg::data_t regs [`REG_COUNT];

    // ----------------------------------------
    // write port
    // ----------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            regs <= '{default: '0};
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;         // visible from the next edge
        end
    end

    // ----------------------------------------
    // read port
    // ----------------------------------------
    assign rd_data = regs[rd_addr];           // no enable, always driven

endmodule

//--- verilog/alu.sv
// ----------------------------------------
// combinational 8-bit ALU
// carry is the ninth bit of add, or the
// borrow of sub, and zero for other ops
// unused op code gives result zero
// ----------------------------------------

`timescale 1ns/1ps

`include "regfile_consts.svh"

module alu (
    input  regfile_pkg::alu_op_t op,
    input  regfile_pkg::data_t   a,
    input  regfile_pkg::data_t   b,
    input  regfile_pkg::data_t   imm,
    output regfile_pkg::data_t   result,
    output logic                 carry
);

    logic [`DATA_WIDTH:0] sum_wide;   // add with carry out
    logic [`DATA_WIDTH:0] diff_wide;  // sub with borrow out

    assign sum_wide  = {1'b0, a} + {1'b0, b};
    assign diff_wide = {1'b0, a} - {1'b0, b};   // top bit set when b > a

    always_comb begin
        result = '0;
        carry  = 1'b0;
        case (op)
            regfile_pkg::op_ldi: begin
                result = imm;
            end
            regfile_pkg::op_mov: begin
                result = a;
            end
            regfile_pkg::op_add: begin
                result = sum_wide[`DATA_WIDTH-1:0];
                carry  = sum_wide[`DATA_WIDTH];
            end
            regfile_pkg::op_sub: begin
                result = diff_wide[`DATA_WIDTH-1:0];
                carry  = diff_wide[`DATA_WIDTH];
            end
            regfile_pkg::op_and: begin
                result = a & b;
            end
            regfile_pkg::op_or: begin
                result = a | b;
            end
            regfile_pkg::op_xor: begin
                result = a ^ b;
            end
            default: begin
                result = '0;                 // spare code
                carry  = 1'b0;
            end
        endcase
    end

endmodule

//--- verilog/cmd_ctrl.sv
// ----------------------------------------
// four-phase req/ack command controller
// one command in flight, fields must hold
// while req is high
// ack rises two edges after req is seen
// and falls on the first edge with req low
// ----------------------------------------

`timescale 1ns/1ps

module cmd_ctrl (
    input  logic                   clk,
    input  logic                   arst_n,
    // host side
    input  logic                   req,
    output logic                   ack,
    input  regfile_pkg::alu_op_t   op,
    input  regfile_pkg::reg_addr_t dst,
    input  regfile_pkg::reg_addr_t src_l,
    input  regfile_pkg::reg_addr_t src_r,
    input  regfile_pkg::data_t     imm,
    output regfile_pkg::data_t     result,
    output logic                   carry,
    // register banks and ALU
    output regfile_pkg::reg_addr_t rd_l_addr,
    output regfile_pkg::reg_addr_t rd_r_addr,
    output regfile_pkg::alu_op_t   alu_op,
    output regfile_pkg::data_t     alu_imm,
    input  regfile_pkg::data_t     alu_result,
    input  logic                   alu_carry,
    output logic                   wr_en,
    output regfile_pkg::reg_addr_t wr_addr,
    output regfile_pkg::data_t     wr_data
);

    regfile_pkg::ctrl_state_t state;

    // captured command
    regfile_pkg::alu_op_t   op_q;
    regfile_pkg::reg_addr_t dst_q;
    regfile_pkg::reg_addr_t src_l_q;
    regfile_pkg::reg_addr_t src_r_q;
    regfile_pkg::data_t     imm_q;

    // ----------------------------------------
    // state machine and result hold
    // ----------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= regfile_pkg::st_idle;
            result <= '0;
            carry  <= 1'b0;
        end else begin
            case (state)
                regfile_pkg::st_idle: begin
                    if (req) begin
                        state <= regfile_pkg::st_exec;
                    end
                end
                regfile_pkg::st_exec: begin
                    state  <= regfile_pkg::st_done;  // write-back on this edge
                    result <= alu_result;
                    carry  <= alu_carry;
                end
                regfile_pkg::st_done: begin
                    if (!req) begin
                        state <= regfile_pkg::st_idle;
                    end
                end
                default: begin
                    state <= regfile_pkg::st_idle;
                end
            endcase
        end
    end

    // ----------------------------------------
    // command capture
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (state == regfile_pkg::st_idle && req) begin
            op_q    <= op;
            dst_q   <= dst;
            src_l_q <= src_l;
            src_r_q <= src_r;
            imm_q   <= imm;
        end
    end

    assign ack       = (state == regfile_pkg::st_done);
    assign wr_en     = (state == regfile_pkg::st_exec);  // single cycle per command
    assign wr_addr   = dst_q;
    assign wr_data   = alu_result;
    assign rd_l_addr = src_l_q;        // stable through exec
    assign rd_r_addr = src_r_q;
    assign alu_op    = op_q;
    assign alu_imm   = imm_q;

endmodule

//--- verilog/regfile_alu_top.sv
// ----------------------------------------
// register file and ALU execution unit
// two banks take every write and give the
// left and right read ports
// host talks four-phase req/ack
// ----------------------------------------

`timescale 1ns/1ps

module regfile_alu_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   req,
    output logic                   ack,
    input  regfile_pkg::alu_op_t   op,
    input  regfile_pkg::reg_addr_t dst,
    input  regfile_pkg::reg_addr_t src_l,
    input  regfile_pkg::reg_addr_t src_r,
    input  regfile_pkg::data_t     imm,
    output regfile_pkg::data_t     result,
    output logic                   carry
);

    // write path, shared by both banks
    logic                   wr_en;
    regfile_pkg::reg_addr_t wr_addr;
    regfile_pkg::data_t     wr_data;

    // read ports
    regfile_pkg::reg_addr_t rd_l_addr;
    regfile_pkg::reg_addr_t rd_r_addr;
    regfile_pkg::data_t     rd_l_data;
    regfile_pkg::data_t     rd_r_data;

    // ALU
    regfile_pkg::alu_op_t   alu_op;
    regfile_pkg::data_t     alu_imm;
    regfile_pkg::data_t     alu_result;
    logic                   alu_carry;

    cmd_ctrl ctrl_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .req        (req),
        .ack        (ack),
        .op         (op),
        .dst        (dst),
        .src_l      (src_l),
        .src_r      (src_r),
        .imm        (imm),
        .result     (result),
        .carry      (carry),
        .rd_l_addr  (rd_l_addr),
        .rd_r_addr  (rd_r_addr),
        .alu_op     (alu_op),
        .alu_imm    (alu_imm),
        .alu_result (alu_result),
        .alu_carry  (alu_carry),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data)
    );

    reg_bank bank_l_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_l_addr),
        .rd_data (rd_l_data)
    );

    reg_bank bank_r_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_r_addr),
        .rd_data (rd_r_data)
    );

    alu alu_i (
        .op     (alu_op),
        .a      (rd_l_data),
        .b      (rd_r_data),
        .imm    (alu_imm),
        .result (alu_result),
        .carry  (alu_carry)
    );

endmodule

//--- test/regfile_alu_props.sv
// ----------------------------------------
// handshake and write-strobe properties
// bound into every cmd_ctrl instance
// ----------------------------------------

`timescale 1ns/1ps

module regfile_alu_props (
    input logic                     clk,
    input logic                     arst_n,
    input logic                     req,
    input logic                     ack,
    input logic                     wr_en,
    input regfile_pkg::ctrl_state_t state
);

    // ack only answers a pending req
    ack_needs_req: assert property (
        @(posedge clk) disable iff (!arst_n) $rose(ack) |-> req
    ) else $error("ack rose while req was low");

    // back-pressure keeps ack up
    ack_holds: assert property (
        @(posedge clk) disable iff (!arst_n) (ack && req) |=> ack
    ) else $error("ack fell while req was high");

    // one write strobe per command, answered by ack
    wr_en_pulse: assert property (
        @(posedge clk) disable iff (!arst_n)
            wr_en |=> (!wr_en && $rose(ack))
    ) else $error("wr_en was not a single-cycle pulse");

    ack_after_reset: assert property (
        @(posedge clk) $rose(arst_n) |-> (!ack && state == regfile_pkg::st_idle)
    ) else $error("ack high or controller busy right after reset release");

endmodule

bind cmd_ctrl regfile_alu_props props_i (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (req),
    .ack    (ack),
    .wr_en  (wr_en),
    .state  (state)
);

//--- test/tb_regfile_alu.sv
// ----------------------------------------
// testbench for the register/ALU unit
// reads test/regfile_stimulus.txt, so run it
// from the project root
// random idle gaps and req hold times
// ----------------------------------------

`timescale 1ns/1ps

module tb_regfile_alu;

    localparam int ack_limit = 10;   // cycles allowed for each ack edge

    logic                   clk;
    logic                   arst_n;
    logic                   req;
    logic                   ack;
    regfile_pkg::alu_op_t   op;
    regfile_pkg::reg_addr_t dst;
    regfile_pkg::reg_addr_t src_l;
    regfile_pkg::reg_addr_t src_r;
    regfile_pkg::data_t     imm;
    regfile_pkg::data_t     result;
    logic                   carry;

    // stimulus table, one entry per command
    logic [2:0]             q_op[$];
    regfile_pkg::reg_addr_t q_dst[$];
    regfile_pkg::reg_addr_t q_src_l[$];
    regfile_pkg::reg_addr_t q_src_r[$];
    regfile_pkg::data_t     q_imm[$];
    regfile_pkg::data_t     q_result[$];
    logic                   q_carry[$];

    int cmd_count;
    bit loaded;
    int pass_cnt;
    int fail_cnt;

    regfile_alu_top dut_i (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .ack    (ack),
        .op     (op),
        .dst    (dst),
        .src_l  (src_l),
        .src_r  (src_r),
        .imm    (imm),
        .result (result),
        .carry  (carry)
    );

    always #2 clk = ~clk;            // 4 ns period

    // ----------------------------------------
    // stimulus file
    // ----------------------------------------
    task automatic load_stimulus();
        int                     fd;
        int                     n;
        string                  line;
        logic [2:0]             f_op;
        regfile_pkg::reg_addr_t f_dst;
        regfile_pkg::reg_addr_t f_src_l;
        regfile_pkg::reg_addr_t f_src_r;
        regfile_pkg::data_t     f_imm;
        regfile_pkg::data_t     f_result;
        logic                   f_carry;
        fd = $fopen("test/regfile_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file test/regfile_stimulus.txt");
            fail_cnt++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin   // skip comments
                    n = $sscanf(line, "%h %h %h %h %h %h %h", f_op, f_dst, f_src_l,
                                f_src_r, f_imm, f_result, f_carry);
                    if (n == 7) begin
                        q_op.push_back(f_op);
                        q_dst.push_back(f_dst);
                        q_src_l.push_back(f_src_l);
                        q_src_r.push_back(f_src_r);
                        q_imm.push_back(f_imm);
                        q_result.push_back(f_result);
                        q_carry.push_back(f_carry);
                    end else begin
                        $display("malformed stimulus line: %s", line);
                        fail_cnt++;
                    end
                end
            end
            $fclose(fd);
        end
        cmd_count = q_op.size();
    endtask

    task automatic check_outputs(input int idx, inout bit ok);
        assert (result == q_result[idx]) else begin
            $display("error result exp=%h got=%h in command %0d", q_result[idx], result, idx);
            ok = 1'b0;
        end
        assert (carry == q_carry[idx]) else begin
            $display("error carry exp=%h got=%h in command %0d", q_carry[idx], carry, idx);
            ok = 1'b0;
        end
    endtask

    // ----------------------------------------
    // one four-phase command
    // ----------------------------------------
    task automatic run_command(input int idx);
        int cycles;
        int hold;
        bit ok;
        ok   = 1'b1;
        hold = $urandom_range(5, 0);
        @(posedge clk);
        req   <= 1'b1;
        op    <= regfile_pkg::alu_op_t'(q_op[idx]);
        dst   <= q_dst[idx];
        src_l <= q_src_l[idx];
        src_r <= q_src_r[idx];
        imm   <= q_imm[idx];
        cycles = 0;
        @(negedge clk);
        while (!ack && cycles < ack_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!ack) begin
            $display("command %0d: ack did not rise within %0d cycles", idx, ack_limit);
            ok = 1'b0;
        end else begin
            check_outputs(idx, ok);
            repeat (hold) begin                     // req held, outputs must not move
                @(negedge clk);
                assert (ack) else begin
                    $display("command %0d: ack fell while req was still high", idx);
                    ok = 1'b0;
                end
                check_outputs(idx, ok);
            end
        end
        @(posedge clk);
        req <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (ack && cycles < ack_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (ack) begin
            $display("command %0d: ack did not fall within %0d cycles", idx, ack_limit);
            ok = 1'b0;
        end
        if (ok) pass_cnt++;
        else fail_cnt++;
        $display("command %0d op=%0d dst=%0d src_l=%0d src_r=%0d imm=%h result=%h carry=%h %s",
                 idx, q_op[idx], q_dst[idx], q_src_l[idx], q_src_r[idx], q_imm[idx],
                 result, carry, ok ? "pass" : "fail");
    endtask

    initial begin
        int gap;
        clk      = 1'b0;
        arst_n   <= 1'b0;
        req      <= 1'b0;
        op       <= regfile_pkg::op_ldi;
        dst      <= '0;
        src_l    <= '0;
        src_r    <= '0;
        imm      <= '0;
        pass_cnt = 0;
        fail_cnt = 0;
        loaded   = 1'b0;
        void'($urandom(56428));
        load_stimulus();
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        for (int i = 0; i < cmd_count; i++) begin
            run_command(i);
            gap = $urandom_range(3, 0);
            repeat (gap) @(posedge clk);
        end
        $display("commands passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && cmd_count > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // watchdog, sized from the command count
    initial begin
        wait (loaded);
        repeat (cmd_count * 30 + 100) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", cmd_count * 30 + 100);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- test/regfile_stimulus.txt
# columns in hex: op dst src_l src_r imm exp_result exp_carry
# op codes: 0 ldi, 1 mov, 2 add, 3 sub, 4 and, 5 or, 6 xor
1 0 0 0 00 00 0
1 1 1 1 00 00 0
1 2 2 2 00 00 0
1 3 3 3 00 00 0
0 0 0 0 3c 3c 0
0 1 0 0 a5 a5 0
0 2 0 0 f0 f0 0
0 3 0 0 0f 0f 0
1 0 0 0 00 3c 0
1 1 1 1 00 a5 0
1 2 2 2 00 f0 0
1 3 3 3 00 0f 0
2 0 1 3 00 b4 0
2 1 1 2 00 95 1
3 2 2 3 00 e1 0
3 3 3 0 00 5b 1
4 0 1 2 00 81 0
5 1 2 3 00 fb 0
6 2 3 0 00 da 0
4 3 1 1 00 fb 0
6 0 2 2 00 00 0
5 1 3 3 00 fb 0
2 2 2 2 00 b4 1
1 0 2 0 00 b4 0
3 3 3 1 00 00 0
1 3 3 3 00 00 0
2 1 1 0 00 af 1
1 1 1 1 00 af 0

//--- verilog.f
+incdir+verilog
verilog/regfile_pkg.sv
verilog/reg_bank.sv
verilog/alu.sv
verilog/cmd_ctrl.sv
verilog/regfile_alu_top.sv
test/regfile_alu_props.sv
test/tb_regfile_alu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the register/ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

verilator --binary --assert --timescale 1ns/1ps -f verilog.f \
    --top-module tb_regfile_alu -Mdir "$obj"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$obj/Vtb_regfile_alu" > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$log"; then
    echo "simulation reported failures"
    exit 1
fi
if ! grep -q "ALL CHECKS PASSED" "$log"; then
    echo "simulation ended without a verdict"
    exit 1
fi
echo "simulation passed"
exit 0
